/* verilog/corr_pkg.sv */
// Shared sizes and types for the PDM lag correlator
// Sample, accumulator and output word types
// Baseline mic pair tables and FSM state enums
package corr_pkg;

  // Array sizes
  localparam int NUM_MICS      = 3;
  localparam int NUM_LAGS      = 8;
  localparam int NUM_BASELINES = 3;

  // PDM bits per decimated sample
  localparam int DECIM_RATIO = 8;
  // Integrator and comb stage count
  localparam int CIC_STAGES  = 3;
  // Samples summed per integration period
  localparam int INTEG_LEN   = 4;

  // CIC register, holds the 8^3 gain without wrap
  typedef logic signed [11:0] cic_acc_t;
  // Decimated sample, comb output sign extended
  typedef logic signed [15:0] sample_t;
  // Lag accumulator, wraps on overflow
  typedef logic signed [31:0] acc_t;
  // Output stream word
  typedef logic        [31:0] word_t;

  typedef logic [2:0] lag_idx_t;
  typedef logic [1:0] bl_idx_t;

  // Mic pairs in order (0,1), (0,2), (1,2)
  localparam int BL_MIC_A [NUM_BASELINES] = '{0, 0, 1};
  localparam int BL_MIC_B [NUM_BASELINES] = '{1, 2, 2};

  // Correlator sweep FSM
  typedef enum logic {
    CORR_IDLE,
    CORR_SWEEP
  } corr_state_e;

  // Packet sequencer FSM
  typedef enum logic [1:0] {
    PACK_IDLE,
    PACK_HEADER,
    PACK_LAGS
  } pack_state_e;

endpackage

/* verilog/sample_if.sv */
// Decimated sample bus from the input side to the correlator
// One strobe shared by all mics, one sample per mic
interface sample_if import corr_pkg::*; ();

  // Single-cycle strobe, samples valid only while high
  logic    sample_strobe;
  // Newest decimated sample of each mic
  sample_t samples [NUM_MICS];

  // Driven by the mic front end
  modport source (
    output sample_strobe,
    output samples
  );

  // Read by the lag correlator
  modport sink (
    input sample_strobe,
    input samples
  );

endinterface

/* verilog/lag_if.sv */
// Finished lag sums from the correlator to the packet builder
// One beat per lag, all baselines side by side
interface lag_if import corr_pkg::*; ();

  // High once per lag on the final sweep of a period
  logic     lag_valid;
  logic     frame_done;
  lag_idx_t lag_idx;
  // Sum for this lag, one per baseline
  acc_t     lag_sum [NUM_BASELINES];

  modport source (
    output lag_valid,
    output lag_idx,
    output lag_sum,
    output frame_done
  );

  modport sink (
    input lag_valid,
    input lag_idx,
    input lag_sum,
    input frame_done
  );

endinterface

/* verilog/cic_decimator.sv */
// Three-stage CIC decimator for a single PDM mic
// Integrators run at the bit rate, combs on the decimation tick
module cic_decimator import corr_pkg::*; (
  input  logic    clk_in,
  input  logic    i_rst,
  input  logic    i_bit_valid,
  input  logic    i_bit,
  input  logic    i_decim_tick,
  output sample_t o_sample
);

  // Integrator chain and its next values
  cic_acc_t integ      [CIC_STAGES];
  cic_acc_t integ_next [CIC_STAGES];
  // Comb one-sample delays and differences
  cic_acc_t comb_dly   [CIC_STAGES];
  cic_acc_t comb_diff  [CIC_STAGES];
  // Bit mapped to +1 or -1
  cic_acc_t bit_val;

  // Cascaded integrators, each stage adds the updated stage before it
  always_comb begin
    bit_val = i_bit ? cic_acc_t'(1) : cic_acc_t'(-1);
    integ_next[0] = integ[0] + bit_val;
    for (int s = 1; s < CIC_STAGES; s++) begin
      integ_next[s] = integ[s] + integ_next[s-1];
    end
  end

  // Comb chain on the last integrator value
  always_comb begin
    comb_diff[0] = integ[CIC_STAGES-1] - comb_dly[0];
    for (int s = 1; s < CIC_STAGES; s++) begin
      comb_diff[s] = comb_diff[s-1] - comb_dly[s];
    end
  end

  always_ff @(posedge clk_in) begin
    if (i_rst) begin
      for (int s = 0; s < CIC_STAGES; s++) begin
        integ[s]    <= '0;
        comb_dly[s] <= '0;
      end
      o_sample <= '0;
    end else begin
      // Integrators move only on a valid PDM bit
      if (i_bit_valid) begin
        integ <= integ_next;
      end
      // Decimated rate: store comb delays and register the output
      if (i_decim_tick) begin
        comb_dly[0] <= integ[CIC_STAGES-1];
        for (int s = 1; s < CIC_STAGES; s++) begin
          comb_dly[s] <= comb_diff[s-1];
        end
        // Signed cast sign extends, nothing dropped
        o_sample <= sample_t'(comb_diff[CIC_STAGES-1]);
      end
    end
  end

endmodule

/* verilog/mic_frontend.sv */
// Mic input side
// Shared decimation counter, one CIC per mic, sample strobe
module mic_frontend import corr_pkg::*; (
  input  logic                clk_in,
  input  logic                i_rst,
  input  logic                i_pdm_valid,
  input  logic [NUM_MICS-1:0] i_pdm_data,
  sample_if.source            o_samples
);

  // Valid bits seen in the current group
  logic [$clog2(DECIM_RATIO)-1:0] bit_cnt;
  // Comb enable, one cycle after the group-ending bit
  logic                           decim_tick;
  // Lines up with the registered comb output
  logic                           sample_strobe;
  sample_t                        mic_sample [NUM_MICS];

  always_ff @(posedge clk_in) begin
    if (i_rst) begin
      bit_cnt       <= '0;
      decim_tick    <= 1'b0;
      sample_strobe <= 1'b0;
    end else begin
      decim_tick    <= 1'b0;
      sample_strobe <= decim_tick;
      if (i_pdm_valid) begin
        // Last bit of a group closes it and arms the comb
        if (bit_cnt == DECIM_RATIO - 1) begin
          bit_cnt    <= '0;
          decim_tick <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  // One decimator per mic, all on the same tick
  for (genvar m = 0; m < NUM_MICS; m++) begin : g_mic
    cic_decimator u_cic (
      .clk_in       (clk_in),
      .i_rst        (i_rst),
      .i_bit_valid  (i_pdm_valid),
      .i_bit        (i_pdm_data[m]),
      .i_decim_tick (decim_tick),
      .o_sample     (mic_sample[m])
    );
  end

  assign o_samples.sample_strobe = sample_strobe;
  assign o_samples.samples       = mic_sample;

endmodule

/* verilog/lag_correlator.sv */
// Lag correlator core
// Per-mic sample histories, one-sided lag sweep, multiply-accumulate
// Integration counter and result strobes toward the packer
module lag_correlator import corr_pkg::*; (
  input  logic   clk_in,
  input  logic   i_rst,
  sample_if.sink i_samples,
  lag_if.source  o_lags
);

  corr_state_e                  state;
  // Lag being processed in this sweep cycle
  lag_idx_t                     lag_cnt;
  // Samples already taken in the current period
  logic [$clog2(INTEG_LEN)-1:0] integ_cnt;
  logic                         frame_done_q;
  logic                         first_sample;
  logic                         last_sample;

  // Position 0 holds the newest sample
  sample_t hist [NUM_MICS][NUM_LAGS];
  acc_t    acc  [NUM_BASELINES][NUM_LAGS];
  // Products and updated sums for the current lag
  acc_t    prod     [NUM_BASELINES];
  acc_t    sum_next [NUM_BASELINES];

  assign first_sample = (integ_cnt == 0);
  assign last_sample  = (integ_cnt == INTEG_LEN - 1);

  // Newest sample of mic a times older sample k of mic b
  always_comb begin
    for (int b = 0; b < NUM_BASELINES; b++) begin
      prod[b] = acc_t'(hist[BL_MIC_A[b]][0]) * acc_t'(hist[BL_MIC_B[b]][lag_cnt]);
      // First sample of a period restarts the sum
      sum_next[b] = first_sample ? prod[b] : acc[b][lag_cnt] + prod[b];
    end
  end

  always_ff @(posedge clk_in) begin
    if (i_rst) begin
      state        <= CORR_IDLE;
      lag_cnt      <= '0;
      integ_cnt    <= '0;
      frame_done_q <= 1'b0;
      for (int m = 0; m < NUM_MICS; m++) begin
        for (int k = 0; k < NUM_LAGS; k++) begin
          hist[m][k] <= '0;
        end
      end
      for (int b = 0; b < NUM_BASELINES; b++) begin
        for (int k = 0; k < NUM_LAGS; k++) begin
          acc[b][k] <= '0;
        end
      end
    end else begin
      frame_done_q <= 1'b0;

      // Shift every history on a new sample
      if (i_samples.sample_strobe) begin
        for (int m = 0; m < NUM_MICS; m++) begin
          hist[m][0] <= i_samples.samples[m];
          for (int k = 1; k < NUM_LAGS; k++) begin
            hist[m][k] <= hist[m][k-1];
          end
        end
      end

      case (state)
        CORR_IDLE: begin
          // Sweep begins the cycle after the strobe
          if (i_samples.sample_strobe) begin
            state   <= CORR_SWEEP;
            lag_cnt <= '0;
          end
        end
        CORR_SWEEP: begin
          for (int b = 0; b < NUM_BASELINES; b++) begin
            acc[b][lag_cnt] <= sum_next[b];
          end
          if (lag_cnt == NUM_LAGS - 1) begin
            state   <= CORR_IDLE;
            lag_cnt <= '0;
            // Period bookkeeping after the last lag
            if (last_sample) begin
              integ_cnt    <= '0;
              frame_done_q <= 1'b1;
            end else begin
              integ_cnt <= integ_cnt + 1'b1;
            end
          end else begin
            lag_cnt <= lag_cnt + 1'b1;
          end
        end
        default: state <= CORR_IDLE;
      endcase
    end
  end

  // Finished sums leave directly on the last sweep of a period
  assign o_lags.lag_valid  = (state == CORR_SWEEP) && last_sample;
  assign o_lags.lag_idx    = lag_cnt;
  assign o_lags.lag_sum    = sum_next;
  assign o_lags.frame_done = frame_done_q;

endmodule

/* verilog/frame_packer.sv */
// Export buffer for one finished integration
// Packet sequencer, header plus lag words per baseline
module frame_packer import corr_pkg::*; (
  input  logic  clk_in,
  input  logic  i_rst,
  lag_if.sink   i_lags,
  output logic  o_word_valid,
  output logic  o_word_last,
  output word_t o_word
);

  pack_state_e state;
  bl_idx_t     bl_cnt;
  lag_idx_t    lag_cnt;
  // Baseline index copied into every byte
  word_t       header_word;

  // Held results, one row per baseline
  word_t frame_buf [NUM_BASELINES][NUM_LAGS];

  // Each lag beat lands in its column
  always_ff @(posedge clk_in) begin
    if (i_lags.lag_valid) begin
      for (int b = 0; b < NUM_BASELINES; b++) begin
        frame_buf[b][i_lags.lag_idx] <= word_t'(i_lags.lag_sum[b]);
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (i_rst) begin
      state   <= PACK_IDLE;
      bl_cnt  <= '0;
      lag_cnt <= '0;
    end else begin
      case (state)
        PACK_IDLE: begin
          // Buffer is complete once frame_done arrives
          if (i_lags.frame_done) begin
            state  <= PACK_HEADER;
            bl_cnt <= '0;
          end
        end
        PACK_HEADER: begin
          state   <= PACK_LAGS;
          lag_cnt <= '0;
        end
        PACK_LAGS: begin
          if (lag_cnt == NUM_LAGS - 1) begin
            lag_cnt <= '0;
            // Next packet follows with no gap
            if (bl_cnt == NUM_BASELINES - 1) begin
              state <= PACK_IDLE;
            end else begin
              state  <= PACK_HEADER;
              bl_cnt <= bl_cnt + 1'b1;
            end
          end else begin
            lag_cnt <= lag_cnt + 1'b1;
          end
        end
        default: state <= PACK_IDLE;
      endcase
    end
  end

  assign header_word = {4{{6'd0, bl_cnt}}};

  // Word port follows the sequencer state directly
  assign o_word_valid = (state != PACK_IDLE);
  assign o_word_last  = (state == PACK_LAGS) && (lag_cnt == NUM_LAGS - 1);
  assign o_word       = (state == PACK_HEADER) ? header_word : frame_buf[bl_cnt][lag_cnt];

endmodule

/* verilog/correlator_top.sv */
// Top level of the PDM lag correlator
// Front end, correlator and packer joined by two internal buses
module correlator_top import corr_pkg::*; (
  input  logic                clk_in,
  input  logic                i_rst,
  // PDM bits of all mics, one strobe per bit time
  input  logic                i_pdm_valid,
  input  logic [NUM_MICS-1:0] i_pdm_data,
  // Packet word stream
  output logic                o_word_valid,
  output logic                o_word_last,
  output word_t               o_word
);

  // Decimated samples toward the correlator
  sample_if samples ();
  // Finished lag sums toward the packer
  lag_if    lags ();

  mic_frontend u_frontend (
    .clk_in      (clk_in),
    .i_rst       (i_rst),
    .i_pdm_valid (i_pdm_valid),
    .i_pdm_data  (i_pdm_data),
    .o_samples   (samples)
  );

  lag_correlator u_correlator (
    .clk_in    (clk_in),
    .i_rst     (i_rst),
    .i_samples (samples),
    .o_lags    (lags)
  );

  frame_packer u_packer (
    .clk_in       (clk_in),
    .i_rst        (i_rst),
    .i_lags       (lags),
    .o_word_valid (o_word_valid),
    .o_word_last  (o_word_last),
    .o_word       (o_word)
  );

endmodule

/* test/tb_model.svh */
// Reference model of the lag correlator
// CIC per mic, sample histories, one-sided lag sums, expected frame words

// Model state, wraps like the hardware registers
cic_acc_t m_integ [NUM_MICS][CIC_STAGES];
cic_acc_t m_comb  [NUM_MICS][CIC_STAGES];
sample_t  m_hist  [NUM_MICS][NUM_LAGS];
acc_t     m_acc   [NUM_BASELINES][NUM_LAGS];
int       m_bits;
int       m_samples;
// Expected output stream
word_t    exp_words [$];
logic     exp_last  [$];

task automatic model_reset();
  foreach (m_integ[m, s]) m_integ[m][s] = '0;
  foreach (m_comb[m, s]) m_comb[m][s] = '0;
  foreach (m_hist[m, k]) m_hist[m][k] = '0;
  foreach (m_acc[b, k]) m_acc[b][k] = '0;
  m_bits    = 0;
  m_samples = 0;
  exp_words.delete();
  exp_last.delete();
endtask

// One decimated sample per mic, then the lag sweep
task automatic model_sample();
  cic_acc_t diff;
  cic_acc_t stage_in;
  acc_t     prod;
  logic     first;
  for (int m = 0; m < NUM_MICS; m++) begin
    diff = m_integ[m][CIC_STAGES-1];
    // Comb stages with one-sample delay
    for (int s = 0; s < CIC_STAGES; s++) begin
      stage_in     = diff;
      diff         = diff - m_comb[m][s];
      m_comb[m][s] = stage_in;
    end
    for (int k = NUM_LAGS - 1; k > 0; k--) m_hist[m][k] = m_hist[m][k-1];
    m_hist[m][0] = sample_t'(diff);
  end
  first = (m_samples % INTEG_LEN == 0);
  // Newest of mic a against older sample k of mic b
  for (int b = 0; b < NUM_BASELINES; b++) begin
    for (int k = 0; k < NUM_LAGS; k++) begin
      prod = acc_t'(m_hist[BL_MIC_A[b]][0]) * acc_t'(m_hist[BL_MIC_B[b]][k]);
      m_acc[b][k] = first ? prod : m_acc[b][k] + prod;
    end
  end
  m_samples++;
  // End of a period, one packet per baseline
  if (m_samples % INTEG_LEN == 0) begin
    for (int b = 0; b < NUM_BASELINES; b++) begin
      exp_words.push_back({4{8'(b)}});
      exp_last.push_back(1'b0);
      for (int k = 0; k < NUM_LAGS; k++) begin
        exp_words.push_back(word_t'(m_acc[b][k]));
        exp_last.push_back(k == NUM_LAGS - 1);
      end
    end
  end
endtask

// One PDM bit per mic, bit 1 is +1 and bit 0 is -1
task automatic model_push(input logic [NUM_MICS-1:0] bits);
  for (int m = 0; m < NUM_MICS; m++) begin
    m_integ[m][0] = m_integ[m][0] + (bits[m] ? 1 : -1);
    for (int s = 1; s < CIC_STAGES; s++) m_integ[m][s] = m_integ[m][s] + m_integ[m][s-1];
  end
  m_bits++;
  if (m_bits % DECIM_RATIO == 0) model_sample();
endtask

/* test/tb_correlator_top.sv */
// Testbench for the PDM lag correlator
// Directed tests, output monitor, compare tasks, timeout and summary
module tb_correlator_top import corr_pkg::*; ();

  localparam int FRAME_WORDS    = NUM_BASELINES * (NUM_LAGS + 1);
  localparam int BITS_PER_FRAME = DECIM_RATIO * INTEG_LEN;
  localparam int CIC_GAIN       = DECIM_RATIO ** CIC_STAGES;
  // Lag sum once all histories hold full-scale samples
  localparam int SETTLED        = INTEG_LEN * CIC_GAIN * CIC_GAIN;
  localparam int RESET_CYCLES   = 8;
  localparam int QUIET_CYCLES   = 200;
  localparam int DRAIN_CYCLES   = 100;
  // Frames per test at 2-cycle spacing, plus the irregular test at up to 5
  localparam int TIMEOUT_CYCLES = QUIET_CYCLES + (6 + 6 + 4 + 2) * BITS_PER_FRAME * 2
                                + 4 * BITS_PER_FRAME * 5
                                + 6 * (RESET_CYCLES + 1 + DRAIN_CYCLES + FRAME_WORDS) + 200;

  logic                clk_in;
  logic                i_rst;
  logic                i_pdm_valid;
  logic [NUM_MICS-1:0] i_pdm_data;
  logic                o_word_valid;
  logic                o_word_last;
  word_t               o_word;

  int    seed;
  int    value_errors;
  int    other_errors;
  int    cycle_cnt;
  int    frame_pos;
  word_t rx_words [$];
  logic  rx_last  [$];

  `include "tb_model.svh"

  correlator_top dut (
    .clk_in       (clk_in),
    .i_rst        (i_rst),
    .i_pdm_valid  (i_pdm_valid),
    .i_pdm_data   (i_pdm_data),
    .o_word_valid (o_word_valid),
    .o_word_last  (o_word_last),
    .o_word       (o_word)
  );

  initial begin
    clk_in = 1'b0;
    forever #2 clk_in = ~clk_in;
  end

  // Output monitor, also flags a break inside a frame
  always @(posedge clk_in) begin
    if (i_rst) begin
      frame_pos <= 0;
    end else if (o_word_valid) begin
      rx_words.push_back(o_word);
      rx_last.push_back(o_word_last);
      frame_pos <= (frame_pos == FRAME_WORDS - 1) ? 0 : frame_pos + 1;
    end else if (frame_pos != 0) begin
      $display("o_word_valid dropped after word %0d of a frame", frame_pos);
      other_errors = other_errors + 1;
      frame_pos <= 0;
    end
  end

  // Run limit
  always @(posedge clk_in) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycle_cnt);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("** Error %s: expected %h, got %h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_last(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("** Error %s: expected last %b, got %b", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("** Error %s: expected count %0d, got %0d", name, exp, act);
      value_errors++;
    end
  endtask

  // Reset held for 8 cycles, model and capture cleared with it
  task automatic reset_dut();
    @(posedge clk_in);
    i_rst       <= 1'b1;
    i_pdm_valid <= 1'b0;
    i_pdm_data  <= '0;
    repeat (RESET_CYCLES) @(posedge clk_in);
    i_rst <= 1'b0;
    model_reset();
    rx_words.delete();
    rx_last.delete();
  endtask

  // One PDM bit per mic, next bit gap cycles later
  task automatic drive_pdm(input logic [NUM_MICS-1:0] bits, input int gap);
    @(posedge clk_in);
    i_pdm_valid <= 1'b1;
    i_pdm_data  <= bits;
    model_push(bits);
    repeat (gap - 1) begin
      @(posedge clk_in);
      i_pdm_valid <= 1'b0;
    end
  endtask

  // Wait for the expected words, then compare the whole stream
  task automatic collect_frames(input string name);
    int waited;
    int n;
    waited = 0;
    while (rx_words.size() < exp_words.size() && waited < DRAIN_CYCLES) begin
      @(posedge clk_in);
      waited++;
    end
    if (rx_words.size() < exp_words.size()) begin
      $display("%s: output frames did not arrive within %0d cycles", name, DRAIN_CYCLES);
      other_errors++;
    end
    // Extra time to catch surplus words
    repeat (FRAME_WORDS) @(posedge clk_in);
    check_count({name, " words"}, exp_words.size(), rx_words.size());
    n = (rx_words.size() < exp_words.size()) ? rx_words.size() : exp_words.size();
    for (int i = 0; i < n; i++) begin
      check_word($sformatf("%s word %0d", name, i), exp_words[i], rx_words[i]);
      check_last($sformatf("%s word %0d", name, i), exp_last[i], rx_last[i]);
    end
  endtask

  // Last frame lag words against the full-scale value, sign per baseline
  task automatic check_settled(input string name, input logic [NUM_BASELINES-1:0] negate);
    int base;
    if (rx_words.size() < FRAME_WORDS) begin
      $display("%s: no complete frame to check the settled values", name);
      other_errors++;
      return;
    end
    base = rx_words.size() - FRAME_WORDS;
    for (int b = 0; b < NUM_BASELINES; b++) begin
      for (int k = 0; k < NUM_LAGS; k++) begin
        check_word($sformatf("%s bl %0d lag %0d", name, b, k),
                   negate[b] ? word_t'(-SETTLED) : word_t'(SETTLED),
                   rx_words[base + b * (NUM_LAGS + 1) + 1 + k]);
      end
    end
  endtask

  task automatic test_quiet();
    int seen;
    seen = 0;
    reset_dut();
    repeat (QUIET_CYCLES) begin
      @(posedge clk_in);
      if (o_word_valid || o_word_last) seen++;
    end
    check_count("quiet", 0, seen);
  endtask

  // Fixed bit pattern on every mic for a number of frames
  task automatic test_constant(input string name, input logic [NUM_MICS-1:0] bits,
                               input logic [NUM_BASELINES-1:0] negate);
    reset_dut();
    for (int i = 0; i < 6 * BITS_PER_FRAME; i++) drive_pdm(bits, 2);
    collect_frames(name);
    check_settled(name, negate);
  endtask

  // Random bits, optionally with random gaps of 2 to 5 cycles
  task automatic test_random_bits(input string name, input int frames, input bit irregular);
    logic [NUM_MICS-1:0] bits;
    int                  gap;
    reset_dut();
    for (int i = 0; i < frames * BITS_PER_FRAME; i++) begin
      bits = $random(seed);
      gap  = irregular ? 2 + ($random(seed) & 3) : 2;
      drive_pdm(bits, gap);
    end
    collect_frames(name);
  endtask

  // Header words and last flags by position within each frame
  task automatic test_framing();
    int pos;
    test_random_bits("framing", 2, 1'b0);
    for (int i = 0; i < rx_words.size(); i++) begin
      pos = i % FRAME_WORDS;
      if (pos % (NUM_LAGS + 1) == 0) begin
        check_word($sformatf("framing header %0d", i),
                   {4{8'(pos / (NUM_LAGS + 1))}}, rx_words[i]);
      end
      check_last($sformatf("framing word %0d", i), pos % (NUM_LAGS + 1) == NUM_LAGS, rx_last[i]);
    end
  endtask

  initial begin
    i_rst        = 1'b1;
    i_pdm_valid  = 1'b0;
    i_pdm_data   = '0;
    seed         = 32'h1c25;
    value_errors = 0;
    other_errors = 0;
    cycle_cnt    = 0;
    frame_pos    = 0;

    test_quiet();
    test_constant("ones", 3'b111, 3'b000);
    // Mic 0 high, mics 1 and 2 low
    test_constant("mixed", 3'b001, 3'b011);
    test_random_bits("random", 4, 1'b0);
    test_framing();
    test_random_bits("irregular", 4, 1'b1);

    $display("Errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* correlator_top.f */
+incdir+test
verilog/corr_pkg.sv
verilog/sample_if.sv
verilog/lag_if.sv
verilog/cic_decimator.sv
verilog/mic_frontend.sv
verilog/lag_correlator.sv
verilog/frame_packer.sv
verilog/correlator_top.sv
test/tb_correlator_top.sv
